//--- mips_settings.svh
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// First fetch address after reset
`define MIPS_RESET_VECTOR 32'hbfc00000

// JR to this address stops the core
`define MIPS_HALT_ADDR 32'h00000000

// Architectural register count
`define MIPS_NUM_REGS 32

`endif

//--- mips_pkg.sv
`default_nettype none

package mips_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_ADDIU = 6'h09,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // R-type function codes
    typedef enum logic [5:0] {
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLTU = 6'h2b
    } funct_e;

    // How alu_control picks the operation
    typedef enum logic [1:0] {
        ALU_CLASS_ADD,
        ALU_CLASS_SUB,
        ALU_CLASS_FUNCT,
        ALU_CLASS_LOGIC
    } alu_class_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLTU,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        logic       reg_dst;
        logic       alu_src;
        logic       zero_ext;
        logic       mem_read;
        logic       mem_write;
        logic       mem_to_reg;
        logic       reg_write;
        logic       branch;
        logic       jump;
        alu_class_e alu_class;
    } ctrl_t;

endpackage

`default_nettype wire

//--- control.sv
`default_nettype none
`timescale 1ns/1ps

module control (
    input  mips_pkg::opcode_e opcode,
    input  mips_pkg::funct_e  funct,
    output mips_pkg::ctrl_t   ctrl,
    output logic              jr
);
    import mips_pkg::*;

    always_comb begin
        // Unknown opcodes fall through as a no-op
        ctrl = '0;
        ctrl.alu_class = ALU_CLASS_ADD;
        jr = 1'b0;

        case (opcode)
            OP_RTYPE: begin
                ctrl.reg_dst = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_class = ALU_CLASS_FUNCT;
                if (funct == FN_JR) begin
                    jr = 1'b1;
                    // JR has no destination register
                    ctrl.reg_write = 1'b0;
                end
            end
            OP_ADDIU: begin
                ctrl.alu_src = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OP_ANDI, OP_ORI: begin
                ctrl.alu_src = 1'b1;
                ctrl.zero_ext = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_class = ALU_CLASS_LOGIC;
            end
            OP_LW: begin
                ctrl.alu_src = 1'b1;
                ctrl.mem_read = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OP_SW: begin
                ctrl.alu_src = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            OP_BEQ: begin
                // Compare by subtraction, zero flag decides
                ctrl.branch = 1'b1;
                ctrl.alu_class = ALU_CLASS_SUB;
            end
            OP_J: begin
                ctrl.jump = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- alu_control.sv
`default_nettype none
`timescale 1ns/1ps

module alu_control (
    input  mips_pkg::alu_class_e alu_class,
    input  mips_pkg::funct_e     funct,
    input  mips_pkg::opcode_e    opcode,
    output mips_pkg::alu_op_e    alu_op
);
    import mips_pkg::*;

    always_comb begin
        case (alu_class)
            ALU_CLASS_ADD: alu_op = ALU_ADD;
            ALU_CLASS_SUB: alu_op = ALU_SUB;
            ALU_CLASS_FUNCT: begin
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLTU: alu_op = ALU_SLTU;
                    default: alu_op = ALU_PASS_B;
                endcase
            end
            // ANDI or ORI
            default: alu_op = (opcode == OP_ANDI) ? ALU_AND : ALU_OR;
        endcase
    end

endmodule

`default_nettype wire

//--- alu.sv
`default_nettype none
`timescale 1ns/1ps

module alu (
    input  mips_pkg::alu_op_e alu_op,
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    output logic [31:0]       result,
    output logic              zero
);
    import mips_pkg::*;

    always_comb begin
        // Wrap-around arithmetic, no overflow trap
        case (alu_op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLTU: result = {31'b0, (a < b)};
            default:  result = b;
        endcase
    end

    // BEQ looks at this after a subtract
    assign zero = (result == 32'b0);

endmodule

`default_nettype wire

//--- regfile.sv
`default_nettype none
`timescale 1ns/1ps
`include "mips_settings.svh"

module regfile (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        clk_enable,
    input  logic        write_enable,
    input  logic [4:0]  read_index_a,
    input  logic [4:0]  read_index_b,
    input  logic [4:0]  write_index,
    input  logic [31:0] write_data,
    output logic [31:0] read_data_a,
    output logic [31:0] read_data_b,
    output logic [31:0] register_v0
);

    logic [31:0] regs [`MIPS_NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= 32'b0;
            end
        end else if (clk_enable && write_enable && (write_index != 5'd0)) begin
            // $zero is never written, so it reads back as 0
            regs[write_index] <= write_data;
        end
    end

    // Combinational reads
    assign read_data_a = regs[read_index_a];
    assign read_data_b = regs[read_index_b];

    // $v0 tap for the outside
    assign register_v0 = regs[2];

endmodule

`default_nettype wire

//--- pc_unit.sv
`default_nettype none
`timescale 1ns/1ps
`include "mips_settings.svh"

module pc_unit (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            clk_enable,
    input  mips_pkg::ctrl_t ctrl,
    input  logic            jr,
    input  logic            zero,
    input  logic [15:0]     imm,
    input  logic [25:0]     jump_target,
    input  logic [31:0]     rs_data,
    output logic [31:0]     pc,
    output logic            active
);

    logic [31:0] pc_plus4;
    logic [31:0] branch_addr;
    logic [31:0] jump_addr;
    logic [31:0] next_pc;
    logic        halt;

    assign pc_plus4 = pc + 32'd4;
    // Word offset, sign-extended
    assign branch_addr = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
    // Stays in the current 256 MB region
    assign jump_addr = {pc_plus4[31:28], jump_target, 2'b00};
    assign halt = jr && (rs_data == `MIPS_HALT_ADDR);

    always_comb begin
        if (ctrl.branch && zero) begin
            next_pc = branch_addr;
        end else if (ctrl.jump) begin
            next_pc = jump_addr;
        end else if (jr) begin
            next_pc = rs_data;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `MIPS_RESET_VECTOR;
            active <= 1'b1;
        end else if (clk_enable && active) begin
            pc <= next_pc;
            // Once halted nothing moves until the next reset
            if (halt) begin
                active <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- mips_cpu_harvard.sv
`default_nettype none
`timescale 1ns/1ps

module mips_cpu_harvard (
    input  logic        clk,
    input  logic        arst_n,
    output logic        active,
    output logic [31:0] register_v0,

    input  logic        clk_enable,

    // Instruction port, read only
    output logic [31:0] instr_address,
    input  logic [31:0] instr_readdata,

    // Data port
    output logic [31:0] data_address,
    output logic        data_write,
    output logic        data_read,
    output logic [31:0] data_writedata,
    input  logic [31:0] data_readdata
);
    import mips_pkg::*;

    opcode_e     opcode;
    funct_e      funct;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [15:0] imm;
    logic [25:0] jump_target;

    ctrl_t       ctrl;
    logic        jr;
    alu_op_e     alu_op;

    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [31:0] imm_ext;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic        alu_zero;
    logic [4:0]  wb_index;
    logic [31:0] wb_data;
    logic        wb_enable;

    // Instruction fields
    assign opcode = opcode_e'(instr_readdata[31:26]);
    assign funct = funct_e'(instr_readdata[5:0]);
    assign rs = instr_readdata[25:21];
    assign rt = instr_readdata[20:16];
    assign rd = instr_readdata[15:11];
    assign imm = instr_readdata[15:0];
    assign jump_target = instr_readdata[25:0];

    control u_control (
        .opcode (opcode),
        .funct  (funct),
        .ctrl   (ctrl),
        .jr     (jr)
    );

    alu_control u_alu_control (
        .alu_class (ctrl.alu_class),
        .funct     (funct),
        .opcode    (opcode),
        .alu_op    (alu_op)
    );

    // ANDI and ORI take a zero-extended immediate
    assign imm_ext = ctrl.zero_ext ? {16'b0, imm} : {{16{imm[15]}}, imm};
    assign alu_b = ctrl.alu_src ? imm_ext : rt_data;

    alu u_alu (
        .alu_op (alu_op),
        .a      (rs_data),
        .b      (alu_b),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // Write-back select
    assign wb_index = ctrl.reg_dst ? rd : rt;
    assign wb_data = ctrl.mem_to_reg ? data_readdata : alu_result;
    assign wb_enable = ctrl.reg_write && active;

    regfile u_regfile (
        .clk          (clk),
        .arst_n       (arst_n),
        .clk_enable   (clk_enable),
        .write_enable (wb_enable),
        .read_index_a (rs),
        .read_index_b (rt),
        .write_index  (wb_index),
        .write_data   (wb_data),
        .read_data_a  (rs_data),
        .read_data_b  (rt_data),
        .register_v0  (register_v0)
    );

    pc_unit u_pc_unit (
        .clk         (clk),
        .arst_n      (arst_n),
        .clk_enable  (clk_enable),
        .ctrl        (ctrl),
        .jr          (jr),
        .zero        (alu_zero),
        .imm         (imm),
        .jump_target (jump_target),
        .rs_data     (rs_data),
        .pc          (instr_address),
        .active      (active)
    );

    // Memory port, strobes silenced after halt
    assign data_address = alu_result;
    assign data_writedata = rt_data;
    assign data_read = ctrl.mem_read && active;
    assign data_write = ctrl.mem_write && active;

endmodule

`default_nettype wire

//--- tb_mips_cpu.sv
`default_nettype none
`timescale 1ns/1ps
`include "mips_settings.svh"

module tb_mips_cpu;

    localparam int PROG_LEN = 200;
    localparam int DATA_WORDS = 64;
    // Worst case about four cycles per instruction with clk_enable low
    localparam int CYCLE_LIMIT = 4 * PROG_LEN + 100;

    logic        clk;
    logic        arst_n;
    logic        clk_enable;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] instr_address;
    logic [31:0] instr_readdata;
    logic [31:0] data_address;
    logic        data_write;
    logic        data_read;
    logic [31:0] data_writedata;
    logic [31:0] data_readdata;

    logic [31:0] prog [PROG_LEN];
    logic [31:0] dmem [DATA_WORDS];
    // Reference model state
    logic [31:0] m_dmem [DATA_WORDS];
    logic [31:0] m_regs [32];
    logic [31:0] m_pc;
    logic        m_active;
    logic [31:0] lcg_state;
    int          errors;
    int          checks;
    int          cycles;

    mips_cpu_harvard DUT (
        .clk            (clk),
        .arst_n         (arst_n),
        .active         (active),
        .register_v0    (register_v0),
        .clk_enable     (clk_enable),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

    function automatic logic [31:0] rand_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'((rand_next() >> 8) % 32'(n));
    endfunction

    // Unmapped words are the address XOR a fixed word
    // At the halt address this decodes to SW $2, 0($0)
    function automatic logic [31:0] fetch(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - `MIPS_RESET_VECTOR;
        if (offset < 32'(PROG_LEN * 4)) begin
            return prog[offset[9:2]];
        end else begin
            return addr ^ 32'hac020000;
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic build_program();
        int          kind;
        int          target;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [5:0]  fn;
        for (int i = 0; i < PROG_LEN - 2; i++) begin
            kind = rand_below(13);
            rs = 5'(1 + rand_below(7));
            rt = 5'(1 + rand_below(7));
            rd = 5'(1 + rand_below(7));
            imm = 16'(rand_next());
            // Forward only, at most up to the ADDIU before the final JR
            target = i + 1 + rand_below(PROG_LEN - 2 - i);
            case (kind)
                0: fn = 6'h21;
                1: fn = 6'h23;
                2: fn = 6'h24;
                3: fn = 6'h25;
                4: fn = 6'h26;
                default: fn = 6'h2b;
            endcase
            case (kind)
                6: prog[i] = {6'h09, rs, rt, imm};
                7: prog[i] = {6'h0c, rs, rt, imm};
                8: prog[i] = {6'h0d, rs, rt, imm};
                9: prog[i] = {6'h23, 5'd0, rt, 16'(4 * rand_below(DATA_WORDS))};
                10: prog[i] = {6'h2b, 5'd0, rt, 16'(4 * rand_below(DATA_WORDS))};
                11: prog[i] = {6'h04, rs, rt, 16'(target - (i + 1))};
                12: prog[i] = {6'h02, 26'((`MIPS_RESET_VECTOR + 32'(4 * target)) >> 2)};
                default: prog[i] = {6'h00, rs, rt, rd, 5'd0, fn};
            endcase
        end
        // ADDIU $1, $0, 0 then JR $1
        prog[PROG_LEN - 2] = {6'h09, 5'd0, 5'd1, 16'h0000};
        prog[PROG_LEN - 1] = {6'h00, 5'd1, 5'd0, 5'd0, 5'd0, 6'h08};
    endtask

    // One instruction of the reference ISA
    task automatic model_step();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] zimm;
        logic [31:0] addr;
        logic [31:0] next_pc;
        logic [4:0]  rd;
        logic [4:0]  rt;
        ins = fetch(m_pc);
        rt = ins[20:16];
        rd = ins[15:11];
        a = m_regs[ins[25:21]];
        b = m_regs[rt];
        simm = {{16{ins[15]}}, ins[15:0]};
        zimm = {16'h0000, ins[15:0]};
        addr = a + simm;
        next_pc = m_pc + 32'd4;
        case (ins[31:26])
            6'h00: begin
                case (ins[5:0])
                    6'h21: m_regs[rd] = a + b;
                    6'h23: m_regs[rd] = a - b;
                    6'h24: m_regs[rd] = a & b;
                    6'h25: m_regs[rd] = a | b;
                    6'h26: m_regs[rd] = a ^ b;
                    6'h2b: m_regs[rd] = (a < b) ? 32'd1 : 32'd0;
                    6'h08: begin
                        next_pc = a;
                        if (a == `MIPS_HALT_ADDR) begin
                            m_active = 1'b0;
                        end
                    end
                    default: ;
                endcase
            end
            6'h09: m_regs[rt] = a + simm;
            6'h0c: m_regs[rt] = a & zimm;
            6'h0d: m_regs[rt] = a | zimm;
            6'h23: m_regs[rt] = m_dmem[addr[7:2]];
            6'h2b: m_dmem[addr[7:2]] = b;
            6'h04: begin
                if (a == b) begin
                    next_pc = next_pc + {simm[29:0], 2'b00};
                end
            end
            6'h02: next_pc = {next_pc[31:28], ins[25:0], 2'b00};
            default: ;
        endcase
        m_regs[0] = 32'h0;
        m_pc = next_pc;
    endtask

    task automatic check_outputs();
        logic [31:0] ins;
        logic        exp_write;
        logic        exp_read;
        ins = fetch(m_pc);
        exp_write = m_active && (ins[31:26] == 6'h2b);
        exp_read = m_active && (ins[31:26] == 6'h23);
        check_value("instr_address", instr_address, m_pc);
        check_value("active", 32'(active), 32'(m_active));
        check_value("register_v0", register_v0, m_regs[2]);
        check_value("data_write", 32'(data_write), 32'(exp_write));
        check_value("data_read", 32'(data_read), 32'(exp_read));
        if (exp_write) begin
            check_value("data_address", data_address,
                        m_regs[ins[25:21]] + {{16{ins[15]}}, ins[15:0]});
            check_value("data_writedata", data_writedata, m_regs[ins[20:16]]);
        end
    endtask

    // Both memories answer in the same cycle
    always_comb begin
        instr_readdata = fetch(instr_address);
        data_readdata = dmem[data_address[7:2]];
    end

    always @(posedge clk) begin
        if (clk_enable && data_write) begin
            dmem[data_address[7:2]] <= data_writedata;
        end
    end

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: core still running after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        logic [31:0] held_pc;
        logic [31:0] held_v0;
        logic        was_enabled;
        int          halt_cycles;
        arst_n = 1'b0;
        clk_enable = 1'b0;
        errors = 0;
        checks = 0;
        cycles = 0;
        lcg_state = 32'hf48842da;
        build_program();
        for (int i = 0; i < DATA_WORDS; i++) begin
            dmem[i] <= (32'(i) * 32'h9e3779b1) ^ 32'h5a5a0000;
            m_dmem[i] = (32'(i) * 32'h9e3779b1) ^ 32'h5a5a0000;
        end
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = 32'h0;
        end
        m_pc = `MIPS_RESET_VECTOR;
        m_active = 1'b1;

        repeat (2) @(posedge clk);
        #1 arst_n = 1'b1;
        check_value("instr_address", instr_address, `MIPS_RESET_VECTOR);
        check_value("active", 32'(active), 32'd1);

        held_pc = instr_address;
        held_v0 = register_v0;
        was_enabled = 1'b1;
        halt_cycles = 0;
        // Run to the halt, then watch 10 more cycles
        while (halt_cycles < 10) begin
            clk_enable = (rand_below(4) != 0);
            @(negedge clk);
            check_outputs();
            if (!was_enabled) begin
                check_value("held instr_address", instr_address, held_pc);
                check_value("held register_v0", register_v0, held_v0);
            end
            held_pc = instr_address;
            held_v0 = register_v0;
            was_enabled = clk_enable;
            if (!m_active) begin
                halt_cycles++;
            end
            if (clk_enable && m_active) begin
                model_step();
            end
            @(posedge clk);
            #1;
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
mips_pkg.sv
control.sv
alu_control.sv
alu.sv
regfile.sv
pc_unit.sv
mips_cpu_harvard.sv
tb_mips_cpu.sv

//--- Makefile
TOOL       = verilator
FLAGS      = --binary --timing
LINT_FLAGS = --lint-only -Wall
TOP        = tb_mips_cpu
RTL_TOP    = mips_cpu_harvard
FILELIST   = sources.f
OBJDIR     = obj_dir
PASS_MSG   = TEST OK

.PHONY: all run lint clean

all: run

$(OBJDIR)/V$(TOP): $(FILELIST) $(wildcard *.sv *.svh)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(OBJDIR)/V$(TOP)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
